// File: hdl/mmc5.sv
// Mapper top; CPU side and PPU pattern/nametable routing only, no audio and no split screen
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5 import mmc5_pkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ce,            // CPU cycle strobe
	input  logic [`MMC5_PRG_ADDR_W-1:0] prg_ain,
	input  logic [7:0]                  prg_din,
	input  logic                        prg_read,
	input  logic                        prg_write,
	input  logic                        ppu_ce,        // PPU dot strobe
	input  logic                        ppu_in_frame,
	input  logic                        ppu_sprite16,
	input  logic [8:0]                  ppu_cycle,
	input  logic [8:0]                  ppu_scanline,
	input  logic [`MMC5_CHR_ADDR_W-1:0] chr_ain,
	output logic [`MMC5_PRG_OUT_W-1:0]  prg_aout,
	output logic                        prg_allow,
	output logic [7:0]                  prg_dout,
	output logic                        prg_bus_write,
	output logic [`MMC5_CHR_OUT_W-1:0]  chr_aout,
	output logic                        vram_a10,
	output logic                        vram_ce,
	output logic                        irq
);

	prg_mode_e                           prg_mode;
	chr_mode_e                           chr_mode;
	exram_mode_e                         ex_mode;
	logic                                prg_ram_we;
	logic [7:0]                          mirroring;
	logic [2:0]                          prg_ram_bank;
	logic [3:0][7:0]                     prg_bank;
	logic [11:0][`MMC5_CHR_BANK_W-1:0]   chr_bank;
	logic                                chr_last;
	logic [7:0]                          irq_scanline;
	logic                                irq_enable;
	logic [7:0]                          mul_a;
	logic [7:0]                          mul_b;
	logic [7:0]                          ex_rdata;
	logic                                irq_pending;

	mmc5_regs u_regs (
		.clk, .rst_n, .ce, .prg_write, .prg_ain, .prg_din, .ppu_sprite16,
		.prg_mode, .chr_mode, .ex_mode, .prg_ram_we, .mirroring, .prg_ram_bank,
		.prg_bank, .chr_bank, .chr_last, .irq_scanline, .irq_enable, .mul_a, .mul_b
	);

	mmc5_prg_map u_prg_map (
		.prg_ain, .prg_write, .prg_mode, .prg_bank, .prg_ram_bank, .prg_ram_we,
		.prg_aout, .prg_allow
	);

	mmc5_chr_map u_chr_map (
		.chr_ain, .chr_mode, .chr_bank, .chr_last, .mirroring, .ppu_in_frame,
		.ppu_sprite16, .ppu_cycle, .chr_aout, .vram_a10, .vram_ce
	);

	mmc5_exram u_exram (
		.clk, .ce, .prg_write, .prg_ain, .prg_din, .ex_mode, .ppu_in_frame, .ex_rdata
	);

	// Pending flag also feeds the $5204 readback
	mmc5_scanline_irq u_scanline_irq (
		.clk, .rst_n, .ce, .ppu_ce, .prg_read, .prg_ain, .ppu_in_frame, .ppu_scanline,
		.irq_scanline, .irq_enable, .irq_pending, .irq
	);

	mmc5_cpu_readback u_cpu_readback (
		.prg_ain, .ex_mode, .ex_rdata, .irq_pending, .ppu_in_frame, .mul_a, .mul_b,
		.prg_dout, .prg_bus_write
	);

endmodule

// File: hdl/mmc5_chr_map.sv
// CHR mapper and nametable routing, combinational; no split or ExRAM nametable override
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5_chr_map import mmc5_pkg::*; (
	input  logic [`MMC5_CHR_ADDR_W-1:0]        chr_ain,
	input  chr_mode_e                          chr_mode,
	input  logic [11:0][`MMC5_CHR_BANK_W-1:0]  chr_bank,
	input  logic                               chr_last,
	input  logic [7:0]                         mirroring,    // 2 bits per quadrant
	input  logic                               ppu_in_frame,
	input  logic                               ppu_sprite16,
	input  logic [8:0]                         ppu_cycle,
	output logic [`MMC5_CHR_OUT_W-1:0]         chr_aout,
	output logic                               vram_a10,
	output logic                               vram_ce
);

	logic [3:0]                  bank_idx;
	logic [`MMC5_CHR_BANK_W-1:0] bank;
	logic [`MMC5_CHR_BANK_W-1:0] chr_sel; // 1 kB page number
	logic [1:0]                  mirr_bits;

	// Sprite fetches run from cycle 256 to 319
	wire is_bg_fetch = !(ppu_cycle[8] && !ppu_cycle[6]);

	// 0 = sprite set $5120-$5127, 1 = background set $5128-$512B
	wire chr_set = (ppu_sprite16 && ppu_in_frame) ? is_bg_fetch : chr_last;

	// Register index per mode and set
	always_comb begin
		if (!chr_set) begin
			case (chr_mode)
				CHR_8K: bank_idx = 4'd7;
				CHR_4K: bank_idx = {1'b0, chr_ain[12], 2'b11}; // 3 or 7
				CHR_2K: bank_idx = {1'b0, chr_ain[12:11], 1'b1}; // 1, 3, 5, 7
				default: bank_idx = {1'b0, chr_ain[12:10]};
			endcase
		end else begin
			// Background set only covers 4 kB, mirrored into both halves
			case (chr_mode)
				CHR_8K, CHR_4K: bank_idx = 4'd11;
				CHR_2K: bank_idx = {2'b10, chr_ain[11], 1'b1}; // 9 or 11
				default: bank_idx = {2'b10, chr_ain[11:10]};
			endcase
		end
	end

	assign bank = chr_bank[bank_idx];

	// Low page bits come from the address in larger modes
	always_comb begin
		case (chr_mode)
			CHR_8K:  chr_sel = {bank[6:0], chr_ain[12:10]};
			CHR_4K:  chr_sel = {bank[7:0], chr_ain[11:10]};
			CHR_2K:  chr_sel = {bank[8:0], chr_ain[10]};
			default: chr_sel = bank;
		endcase
	end

	assign chr_aout = {`MMC5_CHR_ROM_BASE, chr_sel, chr_ain[9:0]};

	// Quadrant select from A11:A10
	// 00 = CIRAM A, 01 = CIRAM B, 1x leaves CIRAM off
	always_comb begin
		case (chr_ain[11:10])
			2'd0:    mirr_bits = mirroring[1:0];
			2'd1:    mirr_bits = mirroring[3:2];
			2'd2:    mirr_bits = mirroring[5:4];
			default: mirr_bits = mirroring[7:6];
		endcase
	end

	assign vram_a10 = mirr_bits[0];
	assign vram_ce  = chr_ain[13] && !mirr_bits[1]; // Nametable space only

endmodule

// File: hdl/mmc5_cpu_readback.sv
// CPU read mux; combinational, prg_bus_write low means open bus and the mapper stays off the bus
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5_cpu_readback import mmc5_pkg::*; (
	input  logic [`MMC5_PRG_ADDR_W-1:0] prg_ain,
	input  exram_mode_e                 ex_mode,
	input  logic [7:0]                  ex_rdata,
	input  logic                        irq_pending,
	input  logic                        ppu_in_frame,
	input  logic [7:0]                  mul_a,
	input  logic [7:0]                  mul_b,
	output logic [7:0]                  prg_dout,
	output logic                        prg_bus_write // Mapper drives the data bus
);

	wire [15:0] product = mul_a * mul_b; // Unsigned 8x8

	wire ex_sel  = (prg_ain[15:10] == `MMC5_EXRAM_WINDOW);
	wire reg_sel = (prg_ain[15:10] == `MMC5_REG_WINDOW);
	wire ex_readable = (ex_mode == EX_RAM) || (ex_mode == EX_ROM);

	always_comb begin
		prg_bus_write = 1'b1;
		if (ex_sel && ex_readable)
			prg_dout = ex_rdata; // Registered one clk earlier
		else if (reg_sel && (prg_ain[9:0] == REG_IRQ_STATUS))
			prg_dout = {irq_pending, ppu_in_frame, 6'b111111};
		else if (reg_sel && (prg_ain[9:0] == REG_MUL_A))
			prg_dout = product[7:0];
		else if (reg_sel && (prg_ain[9:0] == REG_MUL_B))
			prg_dout = product[15:8];
		else begin
			// Open bus, ExRAM modes 0/1 included
			prg_dout      = 8'hFF;
			prg_bus_write = 1'b0;
		end
	end

endmodule

// File: hdl/mmc5_exram.sv
// 1 KB ExRAM on the CPU port only; read data is registered, valid one clk after the address
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5_exram import mmc5_pkg::*; (
	input  logic                        clk,
	input  logic                        ce,
	input  logic                        prg_write,
	input  logic [`MMC5_PRG_ADDR_W-1:0] prg_ain,
	input  logic [7:0]                  prg_din,
	input  exram_mode_e                 ex_mode,
	input  logic                        ppu_in_frame,
	output logic [7:0]                  ex_rdata
);

	logic [7:0] ram [0:(1 << `MMC5_EXRAM_AW)-1]; // Block RAM

	wire [`MMC5_EXRAM_AW-1:0] ram_addr = prg_ain[`MMC5_EXRAM_AW-1:0];
	wire ex_sel = (prg_ain[15:10] == `MMC5_EXRAM_WINDOW); // $5C00-$5FFF

	// Mode 3 is read-only
	wire ex_we = ce && prg_write && ex_sel && (ex_mode != EX_ROM);

	// Modes 0/1 only take CPU data while rendering, zero otherwise
	wire [7:0] wr_data = ((ex_mode == EX_RAM) || ppu_in_frame) ? prg_din : 8'h00;

	always_ff @(posedge clk) begin
		if (ex_we)
			ram[ram_addr] <= wr_data;
		ex_rdata <= ram[ram_addr]; // Every clk, old data on a same-cycle write
	end

endmodule

// File: hdl/mmc5_params.svh
// Mapper constants; CPU side only, fixed 22-bit PRG/CHR outputs, 8 kB RAM pages from $6000
`ifndef MMC5_PARAMS_SVH
`define MMC5_PARAMS_SVH

// Bus widths
`define MMC5_PRG_ADDR_W 16 // CPU address
`define MMC5_PRG_OUT_W 22 // Mapped PRG address
`define MMC5_CHR_OUT_W 22 // Mapped CHR address
`define MMC5_CHR_ADDR_W 14 // PPU address
`define MMC5_CHR_BANK_W 10 // Upper 2 bits from $5130 plus written byte
`define MMC5_EXRAM_AW 10 // 1 KB extended RAM

// Address windows, compared against prg_ain[15:10]
`define MMC5_REG_WINDOW 6'b010100 // $5000-$53FF
`define MMC5_EXRAM_WINDOW 6'b010111 // $5C00-$5FFF

// Scanline compare target must be below this to fire
`define MMC5_IRQ_LAST_LINE 240

// Upper bits of the mapped save RAM region
// 64 kB of RAM at most, three page bits below this
`define MMC5_PRG_RAM_BASE 6'b111100

// Upper bits of the mapped CHR ROM region
`define MMC5_CHR_ROM_BASE 2'b10

// Address bit that separates sprite set $5120-$5127 from background set $5128-$512B
`define MMC5_BG_SET_BIT 3

`endif

// File: hdl/mmc5_pkg.sv
// Mapper types; register offsets are relative to $5000 and list only the implemented registers
package mmc5_pkg;

	// $5100 PRG bank layout
	typedef enum logic [1:0] {
		PRG_32K    = 2'd0,
		PRG_16K    = 2'd1,
		PRG_16K_8K = 2'd2,
		PRG_8K     = 2'd3
	} prg_mode_e;

	// $5101 CHR page size
	typedef enum logic [1:0] {
		CHR_8K = 2'd0,
		CHR_4K = 2'd1,
		CHR_2K = 2'd2,
		CHR_1K = 2'd3
	} chr_mode_e;

	// $5104 ExRAM usage, only RAM and ROM behave fully here
	typedef enum logic [1:0] {
		EX_NT   = 2'd0,
		EX_ATTR = 2'd1,
		EX_RAM  = 2'd2,
		EX_ROM  = 2'd3
	} exram_mode_e;

	// Register offsets inside the $5000 window
	typedef enum logic [9:0] {
		REG_PRG_MODE = 10'h100, REG_CHR_MODE = 10'h101,
		REG_PRG_PROT_1 = 10'h102, REG_PRG_PROT_2 = 10'h103,
		REG_EX_MODE = 10'h104, REG_MIRROR = 10'h105,
		REG_PRG_RAM_BANK = 10'h113,
		REG_PRG_BANK_0 = 10'h114, REG_PRG_BANK_1 = 10'h115,
		REG_PRG_BANK_2 = 10'h116, REG_PRG_BANK_3 = 10'h117,
		REG_CHR_BANK_0 = 10'h120, REG_CHR_BANK_1 = 10'h121,
		REG_CHR_BANK_2 = 10'h122, REG_CHR_BANK_3 = 10'h123,
		REG_CHR_BANK_4 = 10'h124, REG_CHR_BANK_5 = 10'h125,
		REG_CHR_BANK_6 = 10'h126, REG_CHR_BANK_7 = 10'h127,
		REG_CHR_BANK_8 = 10'h128, REG_CHR_BANK_9 = 10'h129,
		REG_CHR_BANK_A = 10'h12a, REG_CHR_BANK_B = 10'h12b,
		REG_CHR_UPPER = 10'h130,
		REG_IRQ_SCANLINE = 10'h203, REG_IRQ_STATUS = 10'h204,
		REG_MUL_A = 10'h205, REG_MUL_B = 10'h206
	} mmc5_reg_e;

endpackage

// File: hdl/mmc5_prg_map.sv
// PRG address mapper, purely combinational; bank 3 always maps ROM, banks 0-2 bit 7 picks ROM
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5_prg_map import mmc5_pkg::*; (
	input  logic [`MMC5_PRG_ADDR_W-1:0] prg_ain,
	input  logic                        prg_write,
	input  prg_mode_e                   prg_mode,
	input  logic [3:0][7:0]             prg_bank,
	input  logic [2:0]                  prg_ram_bank,
	input  logic                        prg_ram_we,
	output logic [`MMC5_PRG_OUT_W-1:0]  prg_aout,
	output logic                        prg_allow
);

	// Bit 7 high = ROM page, low = RAM page in bits 2:0
	logic [7:0] prg_sel;
	wire  [6:0] last_bank = prg_bank[3][6:0];

	always_comb begin
		prg_sel = {5'b0, prg_ram_bank}; // $6000-$7FFF in every mode
		if (prg_ain[15]) begin
			case (prg_mode)
				PRG_32K: prg_sel = {1'b1, last_bank[6:2], prg_ain[14:13]};
				PRG_16K: begin
					if (prg_ain[14])
						prg_sel = {1'b1, last_bank[6:1], prg_ain[13]};
					else
						prg_sel = {prg_bank[1][7:1], prg_ain[13]};
				end
				PRG_16K_8K: begin
					case (prg_ain[14:13])
						2'b10:   prg_sel = prg_bank[2];          // $C000 8 kB
						2'b11:   prg_sel = {1'b1, last_bank};    // $E000 8 kB
						default: prg_sel = {prg_bank[1][7:1], prg_ain[13]}; // $8000 16 kB
					endcase
				end
				PRG_8K: begin
					if (prg_ain[14:13] == 2'b11)
						prg_sel = {1'b1, last_bank};
					else
						prg_sel = prg_bank[prg_ain[14:13]];
				end
			endcase
		end
	end

	// 8 kB pages, RAM relocated to the save area
	assign prg_aout = {prg_sel[7] ? {2'b00, prg_sel[6:0]} : {`MMC5_PRG_RAM_BASE, prg_sel[2:0]},
		prg_ain[12:0]};

	// Reads anywhere from $6000, writes only to unlocked RAM
	assign prg_allow = (prg_ain >= 16'h6000) && (!prg_write || (!prg_sel[7] && prg_ram_we));

endmodule

// File: hdl/mmc5_regs.sv
// Config registers at $5000-$53FF; writes land on ce edges only, registers are write-only here
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5_regs import mmc5_pkg::*; (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    ce,           // One pulse per CPU cycle
	input  logic                                    prg_write,
	input  logic [`MMC5_PRG_ADDR_W-1:0]             prg_ain,
	input  logic [7:0]                              prg_din,
	input  logic                                    ppu_sprite16, // 8x16 sprites on
	output prg_mode_e                               prg_mode,
	output chr_mode_e                               chr_mode,
	output exram_mode_e                             ex_mode,
	output logic                                    prg_ram_we,   // Both protect keys set
	output logic [7:0]                              mirroring,
	output logic [2:0]                              prg_ram_bank,
	output logic [3:0][7:0]                         prg_bank,
	output logic [11:0][`MMC5_CHR_BANK_W-1:0]       chr_bank,
	output logic                                    chr_last,     // 1 = background set last
	output logic [7:0]                              irq_scanline,
	output logic                                    irq_enable,
	output logic [7:0]                              mul_a,
	output logic [7:0]                              mul_b
);

	logic       prg_protect_1; // $5102 == 2
	logic       prg_protect_2; // $5103 == 1
	logic [1:0] chr_upper;     // $5130, shared top bits of every CHR bank
	logic       old_sprite16;  // For the 8x16 -> 8x8 edge

	wire reg_wr = prg_write && (prg_ain[15:10] == `MMC5_REG_WINDOW);

	assign prg_ram_we = prg_protect_1 & prg_protect_2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prg_mode      <= PRG_8K;
			chr_mode      <= CHR_8K;
			ex_mode       <= EX_NT;
			prg_protect_1 <= 1'b0;
			prg_protect_2 <= 1'b0;
			mirroring     <= 8'h00;
			prg_ram_bank  <= 3'd0;
			prg_bank      <= {8'h7F, 8'h00, 8'h00, 8'h00}; // Last bank at $E000
			chr_bank      <= '0;
			chr_upper     <= 2'd0;
			chr_last      <= 1'b0;
			old_sprite16  <= 1'b0;
			irq_scanline  <= 8'h00;
			irq_enable    <= 1'b0;
			mul_a         <= 8'h00;
			mul_b         <= 8'h00;
		end else if (ce) begin
			if (reg_wr) begin
				case (prg_ain[9:0])
					REG_PRG_MODE:     prg_mode <= prg_mode_e'(prg_din[1:0]);
					REG_CHR_MODE:     chr_mode <= chr_mode_e'(prg_din[1:0]);
					REG_PRG_PROT_1:   prg_protect_1 <= (prg_din[1:0] == 2'b10);
					REG_PRG_PROT_2:   prg_protect_2 <= (prg_din[1:0] == 2'b01);
					REG_EX_MODE:      ex_mode <= exram_mode_e'(prg_din[1:0]);
					REG_MIRROR:       mirroring <= prg_din;
					REG_PRG_RAM_BANK: prg_ram_bank <= prg_din[2:0];
					REG_PRG_BANK_0, REG_PRG_BANK_1, REG_PRG_BANK_2, REG_PRG_BANK_3:
						prg_bank[prg_ain[1:0]] <= prg_din; // Low bits pick the slot
					REG_CHR_BANK_0, REG_CHR_BANK_1, REG_CHR_BANK_2, REG_CHR_BANK_3,
					REG_CHR_BANK_4, REG_CHR_BANK_5, REG_CHR_BANK_6, REG_CHR_BANK_7,
					REG_CHR_BANK_8, REG_CHR_BANK_9, REG_CHR_BANK_A, REG_CHR_BANK_B: begin
						chr_bank[prg_ain[3:0]] <= {chr_upper, prg_din};
						// Set only sticks while 8x16 sprites are on
						chr_last <= prg_ain[`MMC5_BG_SET_BIT] & ppu_sprite16;
					end
					REG_CHR_UPPER:    chr_upper <= prg_din[1:0];
					REG_IRQ_SCANLINE: irq_scanline <= prg_din;
					REG_IRQ_STATUS:   irq_enable <= prg_din[7]; // Bit 7 only
					REG_MUL_A:        mul_a <= prg_din;
					REG_MUL_B:        mul_b <= prg_din;
					default: begin
					end
				endcase
			end

			// Falling 8x16 reverts to the sprite set
			old_sprite16 <= ppu_sprite16;
			if (old_sprite16 && !ppu_sprite16)
				chr_last <= 1'b0;
		end
	end

endmodule

// File: hdl/mmc5_scanline_irq.sv
// Scanline IRQ; relies on ppu_scanline bit 0 toggling once per line, targets 1-239 only
`timescale 1ns/100ps
`include "mmc5_params.svh"

module mmc5_scanline_irq import mmc5_pkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ce,
	input  logic                        ppu_ce,
	input  logic                        prg_read,
	input  logic [`MMC5_PRG_ADDR_W-1:0] prg_ain,
	input  logic                        ppu_in_frame,
	input  logic [8:0]                  ppu_scanline,
	input  logic [7:0]                  irq_scanline, // $5203 target
	input  logic                        irq_enable,
	output logic                        irq_pending,
	output logic                        irq
);

	logic last_line_bit; // Scanline LSB from the last strobe

	// CPU read of $5204 acknowledges
	wire status_ack = ce && prg_read && (prg_ain[15:10] == `MMC5_REG_WINDOW) &&
		(prg_ain[9:0] == REG_IRQ_STATUS);

	// Target 0 or past the visible lines never fires
	wire line_hit = (irq_scanline != 8'd0) && (irq_scanline < `MMC5_IRQ_LAST_LINE) &&
		(ppu_scanline == {1'b0, irq_scanline});

	wire new_line = (ppu_scanline[0] != last_line_bit);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_line_bit <= 1'b0;
			irq_pending   <= 1'b0;
		end else if (ce || ppu_ce) begin
			last_line_bit <= ppu_scanline[0];
			if (status_ack || !ppu_in_frame)
				irq_pending <= 1'b0; // Clear wins over set
			else if (new_line && line_hit)
				irq_pending <= 1'b1;
		end
	end

	assign irq = irq_pending && irq_enable;

endmodule

// File: mmc5.f
+incdir+hdl
hdl/mmc5_pkg.sv
hdl/mmc5_regs.sv
hdl/mmc5_prg_map.sv
hdl/mmc5_chr_map.sv
hdl/mmc5_exram.sv
hdl/mmc5_scanline_irq.sv
hdl/mmc5_cpu_readback.sv
hdl/mmc5.sv
verification/mmc5_tb.sv

// File: verification/mmc5_tb.sv
// Mapper testbench; ce toggles only while stimulus ticks, ppu_ce held high, stops at first error
`timescale 1ns/100ps

module mmc5_tb import mmc5_pkg::*; ();

	localparam int TEST_CYCLES = 2000;            // Generous estimate of the test length
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic        clk, rst_n, ce, ppu_ce, prg_read, prg_write, ppu_in_frame, ppu_sprite16;
	logic [15:0] prg_ain;
	logic [7:0]  prg_din, prg_dout;
	logic [8:0]  ppu_cycle, ppu_scanline;
	logic [13:0] chr_ain;
	logic [21:0] prg_aout, chr_aout;
	logic        prg_allow, prg_bus_write, vram_a10, vram_ce, irq;

	integer      seed;
	int          cycles = 0;
	logic [7:0]  prg_bank_m [0:3]; // Expected register contents
	logic [2:0]  ram_bank_m;
	logic [9:0]  chr_m [0:11];
	logic [7:0]  ex_m [0:1023];
	logic        irq_en_m;
	logic [7:0]  rd, a_op, b_op, mirr;
	logic        bw;
	logic [15:0] prod;
	logic [1:0]  upper;
	int          target, off;

	mmc5 dut (
		.clk, .rst_n, .ce, .prg_ain, .prg_din, .prg_read, .prg_write, .ppu_ce, .ppu_in_frame,
		.ppu_sprite16, .ppu_cycle, .ppu_scanline, .chr_ain, .prg_aout, .prg_allow, .prg_dout,
		.prg_bus_write, .chr_aout, .vram_a10, .vram_ce, .irq
	);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d clock cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$fatal(1);
		end
	end

	// irq must stay quiet until the enable bit is written
	always @(negedge clk)
		if (rst_n && !irq_en_m)
			assert (!irq) else report_failure("irq high while IRQ is disabled");

	task automatic report_failure(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	// One clk; drives land 2 ns after the edge, ce flips each step
	task automatic tick;
		@(posedge clk);
		#2;
		ce = ~ce;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		tick;
		if (!ce)
			tick;
		prg_ain = a;
		prg_din = d;
		prg_write = 1'b1;
		tick; // Edge with ce high takes the write
		prg_write = 1'b0;
	endtask

	// late = sample after the ce edge, needed for registered ExRAM data
	task automatic cpu_read(input logic [15:0] a, input bit late, output logic [7:0] d,
		output logic w);
		tick;
		if (!ce)
			tick;
		prg_ain = a;
		prg_read = 1'b1;
		#1;
		d = prg_dout;
		w = prg_bus_write;
		tick; // $5204 acknowledge happens here
		if (late) begin
			d = prg_dout;
			w = prg_bus_write;
		end
		prg_read = 1'b0;
	endtask

	task automatic line_step(input logic [8:0] line);
		tick;
		ppu_scanline = line;
		tick;
		tick; // Checked a few clks into the line
	endtask

	task automatic set_ppu(input bit in_frame, input bit spr16, input logic [8:0] cyc);
		tick;
		ppu_in_frame = in_frame;
		ppu_sprite16 = spr16;
		ppu_cycle = cyc;
	endtask

	// Mode table over 8 kB pages, bit 7 of a page marks ROM
	function automatic logic [21:0] prg_expect(input int mode, input logic [15:0] a);
		logic [7:0] page;
		case (mode)
			0: page = {1'b1, prg_bank_m[3][6:2], a[14:13]};
			1: page = a[14] ? {1'b1, prg_bank_m[3][6:1], a[13]} : {prg_bank_m[1][7:1], a[13]};
			2: page = !a[14] ? {prg_bank_m[1][7:1], a[13]} :
				(a[13] ? {1'b1, prg_bank_m[3][6:0]} : prg_bank_m[2]);
			default: page = (a[14:13] == 2'b11) ? {1'b1, prg_bank_m[3][6:0]} : prg_bank_m[a[14:13]];
		endcase
		if (!a[15])
			page = {5'd0, ram_bank_m}; // Save RAM window
		return page[7] ? {2'b00, page[6:0], a[12:0]} : {6'b111100, page[2:0], a[12:0]};
	endfunction

	// 1 kB pages; background set repeats every 4 kB
	function automatic logic [21:0] chr_expect(input bit bg, input logic [13:0] a);
		int idx;
		idx = bg ? 8 + a[11:10] : a[12:10];
		return {2'b10, chr_m[idx], a[9:0]};
	endfunction

	task automatic probe_prg(input int mode, input logic [15:0] a);
		tick;
		prg_ain = a;
		#1;
		assert (prg_aout == prg_expect(mode, a))
			else report_failure($sformatf("prg_aout %h at %h, expected %h", prg_aout, a,
				prg_expect(mode, a)));
	endtask

	task automatic check_chr(input bit bg);
		for (int k = 0; k < 8; k++) begin
			tick;
			chr_ain = {1'b0, 3'(k), 10'($random(seed))};
			#1;
			assert (chr_aout == chr_expect(bg, chr_ain))
				else report_failure($sformatf("chr_aout %h at %h, expected %h", chr_aout,
					chr_ain, chr_expect(bg, chr_ain)));
		end
	endtask

	task automatic check_ram_write(input bit allowed);
		tick;
		prg_ain = 16'h6000;
		prg_write = 1'b1;
		#1;
		assert (prg_allow == allowed) else report_failure("prg_allow wrong for $6000 write");
		prg_write = 1'b0;
	endtask

	initial begin
		clk = 0;
		rst_n = 0;
		ce = 0;
		ppu_ce = 1;
		prg_read = 0;
		prg_write = 0;
		prg_ain = 0;
		prg_din = 0;
		chr_ain = 0;
		ppu_cycle = 0;
		ppu_scanline = 0;
		ppu_in_frame = 0;
		ppu_sprite16 = 0;
		irq_en_m = 0;
		seed = 32'h31dc_193b;
		prg_bank_m = '{8'h00, 8'h00, 8'h00, 8'h7F}; // Bank 3 resets to the last page
		ram_bank_m = 3'd0;
		repeat (5) @(posedge clk);
		#2 rst_n = 1;

		probe_prg(3, 16'hE000); // PRG_8K after reset
		for (int m = 0; m < 4; m++) begin
			cpu_write(16'h5100, 8'(m));
			for (int b = 0; b < 4; b++) begin
				prg_bank_m[b] = $random(seed);
				cpu_write(16'h5114 + b, prg_bank_m[b]);
			end
			ram_bank_m = $random(seed);
			cpu_write(16'h5113, {5'd0, ram_bank_m});
			for (int p = 0; p < 4; p++)
				probe_prg(m, {1'b1, 2'(p), 13'($random(seed))});
			probe_prg(m, {3'b011, 13'($random(seed))});
		end

		check_ram_write(0); // Locked after reset
		cpu_write(16'h5102, 8'h02);
		check_ram_write(0); // One key is not enough
		cpu_write(16'h5103, 8'h01);
		check_ram_write(1);
		tick;
		prg_ain = 16'h5000;
		#1;
		assert (!prg_allow) else report_failure("prg_allow high for $5000 read");

		cpu_write(16'h5101, CHR_1K);
		upper = $random(seed);
		cpu_write(16'h5130, upper);
		for (int i = 0; i < 12; i++) begin
			chr_m[i] = {upper, 8'($random(seed))};
			cpu_write(16'h5120 + i, chr_m[i][7:0]);
		end
		check_chr(0); // 8x8 sprites ignore the background writes
		set_ppu(0, 1, 0);
		cpu_write(16'h5128, chr_m[8][7:0]);
		check_chr(1);
		cpu_write(16'h5122, chr_m[2][7:0]);
		check_chr(0);
		set_ppu(1, 1, 9'd0);
		check_chr(1);
		set_ppu(1, 1, 9'd260); // Sprite fetch window
		check_chr(0);
		set_ppu(1, 1, 9'd320);
		check_chr(1);
		set_ppu(0, 1, 0);
		cpu_write(16'h5129, chr_m[9][7:0]);
		check_chr(1);
		set_ppu(0, 0, 0); // 8x16 off, back to sprites once a ce edge sees it
		tick;
		tick;
		check_chr(0);

		mirr = $random(seed);
		cpu_write(16'h5105, mirr);
		for (int q = 0; q < 4; q++) begin
			tick;
			chr_ain = {2'b10, 2'(q), 10'h155};
			#1;
			assert (vram_a10 == mirr[2 * q] && vram_ce == !mirr[2 * q + 1])
				else report_failure($sformatf("nametable routing wrong in quadrant %0d", q));
		end
		tick;
		chr_ain = 14'h0400;
		#1;
		assert (!vram_ce) else report_failure("vram_ce high in pattern space");

		for (int i = 0; i < 6; i++) begin
			a_op = $random(seed);
			b_op = $random(seed);
			prod = 16'(a_op) * 16'(b_op);
			cpu_write(16'h5205, a_op);
			cpu_write(16'h5206, b_op);
			cpu_read(16'h5205, 0, rd, bw);
			assert (bw && rd == prod[7:0]) else report_failure($sformatf("product low %h", rd));
			cpu_read(16'h5206, 0, rd, bw);
			assert (bw && rd == prod[15:8]) else report_failure($sformatf("product high %h", rd));
		end

		cpu_write(16'h5104, EX_RAM);
		for (int i = 0; i < 8; i++) begin
			off = (i * 131 + 5) % 1024;
			ex_m[off] = $random(seed);
			cpu_write(16'h5C00 + off, ex_m[off]);
			cpu_read(16'h5C00 + off, 1, rd, bw); // One clk after the address
			assert (bw && rd == ex_m[off])
				else report_failure($sformatf("ExRAM %h read %h in RAM mode", off, rd));
		end
		cpu_write(16'h5104, EX_ROM); // Read-only from here
		for (int i = 0; i < 8; i++) begin
			off = (i * 131 + 5) % 1024;
			cpu_write(16'h5C00 + off, ~ex_m[off]);
			cpu_read(16'h5C00 + off, 1, rd, bw);
			assert (bw && rd == ex_m[off])
				else report_failure($sformatf("ExRAM %h read %h, expected %h", off, rd, ex_m[off]));
		end
		cpu_read(16'h5300, 0, rd, bw);
		assert (!bw && rd == 8'hFF) else report_failure("unmapped $5300 read drove the bus");

		target = 3 + ($unsigned($random(seed)) % 20);
		set_ppu(1, 0, 0);
		cpu_write(16'h5203, 8'(target));
		cpu_write(16'h5204, 8'h80);
		irq_en_m = 1;
		for (int n = 1; n <= target; n++) begin
			line_step(9'(n));
			assert (irq == (n == target)) else report_failure($sformatf("irq %b on line %0d", irq, n));
		end
		cpu_read(16'h5204, 0, rd, bw); // Pending, in frame, six ones
		assert (bw && rd == 8'hFF && !irq) else report_failure($sformatf("status %h", rd));
		cpu_read(16'h5204, 0, rd, bw);
		assert (rd == 8'h7F) else report_failure($sformatf("status %h after acknowledge", rd));
		cpu_write(16'h5203, 8'h00);
		for (int n = 1; n <= 4; n++) begin
			line_step(9'(n % 4)); // Ends on line 0
			assert (!irq) else report_failure("irq fired with target 0");
		end
		cpu_write(16'h5203, 8'd2);
		line_step(9'd1);
		line_step(9'd2);
		assert (irq) else report_failure("irq missing on line 2");
		cpu_write(16'h5204, 8'h00); // Masked, pending stays set
		irq_en_m = 0;
		tick;
		cpu_write(16'h5204, 8'h80);
		irq_en_m = 1;
		assert (irq) else report_failure("pending lost while irq was masked");
		set_ppu(0, 0, 0);
		tick;
		cpu_read(16'h5204, 0, rd, bw);
		assert (!irq && rd == 8'h3F) else report_failure($sformatf("status %h out of frame", rd));

		$display("All tests passed!");
		$finish;
	end

endmodule
